//--- aluPkg.sv
package aluPkg;

    // Default operand width of the datapath
    localparam int DATA_WIDTH_DEF = 32;

    ////////////////////////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////////////////////////

    // Five bit code delivered with each issued operation
    // Values 23 to 31 are illegal
    typedef enum logic [4:0] {
        OP_ADD     = 5'd0,
        OP_ADDU    = 5'd1,
        OP_SUB     = 5'd2,
        OP_MULT    = 5'd3,
        OP_MULTU   = 5'd4,
        OP_AND     = 5'd5,
        OP_OR      = 5'd6,
        OP_NOR     = 5'd7,
        OP_XOR     = 5'd8,
        OP_SLL     = 5'd9,
        OP_SRL     = 5'd10,
        OP_SLLV    = 5'd11,
        OP_SLT     = 5'd12,
        OP_MOVN    = 5'd13,
        OP_MOVZ    = 5'd14,
        OP_ROTRV   = 5'd15,
        OP_SRA     = 5'd16,
        OP_SRAV    = 5'd17,
        OP_SLTU    = 5'd18,
        OP_MUL     = 5'd19,
        OP_MADD    = 5'd20,
        OP_MSUB    = 5'd21,
        OP_SEH_SEB = 5'd22
    } aluOpT;

    ////////////////////////////////////////////////////////////
    // Operation classes
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        // Plain register result, always written
        CLASS_RESULT  = 2'd0,
        // MOVN or MOVZ where the write depends on B
        CLASS_COND    = 2'd1,
        // Multiply into HI/LO with no register write
        CLASS_HILO    = 2'd2,
        // Code outside the table
        CLASS_ILLEGAL = 2'd3
    } opClassT;

endpackage

//--- operandStage.sv
`timescale 1ns/1ps

module operandStage #(
    parameter  int dataWidth  = aluPkg::DATA_WIDTH_DEF,
    localparam int shamtWidth = $clog2(dataWidth)
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  issueStb,
    input  aluPkg::aluOpT         op,
    input  logic [dataWidth-1:0]  a,
    input  logic [dataWidth-1:0]  b,
    input  logic [shamtWidth-1:0] shamt,
    output logic                  s1Valid,
    output aluPkg::aluOpT         s1Op,
    output logic [dataWidth-1:0]  s1A,
    output logic [dataWidth-1:0]  s1B,
    output logic [shamtWidth-1:0] s1Shamt,
    output aluPkg::opClassT       s1Class
);

    // Class of the operation presented at the input
    aluPkg::opClassT issueClass;

    ////////////////////////////////////////////////////////////
    // Opcode classification
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            // Conditional moves
            aluPkg::OP_MOVN, aluPkg::OP_MOVZ: issueClass = aluPkg::CLASS_COND;
            // Accumulator updates
            aluPkg::OP_MULT, aluPkg::OP_MULTU,
            aluPkg::OP_MADD, aluPkg::OP_MSUB: issueClass = aluPkg::CLASS_HILO;
            // Everything else in the table writes a result
            aluPkg::OP_ADD, aluPkg::OP_ADDU, aluPkg::OP_SUB,
            aluPkg::OP_AND, aluPkg::OP_OR, aluPkg::OP_NOR, aluPkg::OP_XOR,
            aluPkg::OP_SLL, aluPkg::OP_SRL, aluPkg::OP_SRA,
            aluPkg::OP_SLLV, aluPkg::OP_SRAV, aluPkg::OP_ROTRV,
            aluPkg::OP_SLT, aluPkg::OP_SLTU, aluPkg::OP_MUL,
            aluPkg::OP_SEH_SEB: issueClass = aluPkg::CLASS_RESULT;
            default: issueClass = aluPkg::CLASS_ILLEGAL;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Stage 1 registers
    ////////////////////////////////////////////////////////////

    // Valid follows the issue strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issueStb;
        end
    end

    // Operands and code only load on issue
    always_ff @(posedge clk) begin
        if (issueStb) begin
            s1Op    <= op;
            s1A     <= a;
            s1B     <= b;
            s1Shamt <= shamt;
            s1Class <= issueClass;
        end
    end

    // An issued opcode must come from the table
    assert property (@(posedge clk) disable iff (!rstN)
        issueStb |-> (issueClass != aluPkg::CLASS_ILLEGAL))
        else $error("operandStage: illegal opcode issued");

endmodule

//--- aluCore.sv
`timescale 1ns/1ps

module aluCore #(
    parameter  int dataWidth  = aluPkg::DATA_WIDTH_DEF,
    localparam int shamtWidth = $clog2(dataWidth)
) (
    input  aluPkg::aluOpT         s1Op,
    input  logic [dataWidth-1:0]  s1A,
    input  logic [dataWidth-1:0]  s1B,
    input  logic [shamtWidth-1:0] s1Shamt,
    output logic [dataWidth-1:0]  aluResult,
    output logic                  condTrue
);

    // Variable shift amount from the low bits of A
    logic [shamtWidth-1:0] varAmt;

    // B doubled up so a right shift gives the rotation in the low half
    logic [2*dataWidth-1:0] rotPair;

    // Low word of the signed product
    logic [dataWidth-1:0] mulLow;

    // Set-on-less-than flags
    logic ltSigned;
    logic ltUnsigned;

    ////////////////////////////////////////////////////////////
    // Shared helpers
    ////////////////////////////////////////////////////////////

    assign varAmt  = s1A[shamtWidth-1:0];
    assign rotPair = {s1B, s1B} >> varAmt;

    // Low half is the same for signed and unsigned operands
    assign mulLow = $signed(s1A) * $signed(s1B);

    assign ltSigned   = $signed(s1A) < $signed(s1B);
    assign ltUnsigned = s1A < s1B;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (s1Op)
            // Add and subtract, wrap on overflow
            aluPkg::OP_ADD,
            aluPkg::OP_ADDU: aluResult = s1A + s1B;
            aluPkg::OP_SUB:  aluResult = s1A - s1B;

            // Bitwise logic
            aluPkg::OP_AND: aluResult = s1A & s1B;
            aluPkg::OP_OR:  aluResult = s1A | s1B;
            aluPkg::OP_NOR: aluResult = ~(s1A | s1B);
            aluPkg::OP_XOR: aluResult = s1A ^ s1B;

            // Fixed shifts move B by the instruction shamt
            aluPkg::OP_SLL: aluResult = s1B << s1Shamt;
            aluPkg::OP_SRL: aluResult = s1B >> s1Shamt;
            aluPkg::OP_SRA: aluResult = $signed(s1B) >>> s1Shamt;

            // Variable shifts move B by A
            aluPkg::OP_SLLV:  aluResult = s1B << varAmt;
            aluPkg::OP_SRAV:  aluResult = $signed(s1B) >>> varAmt;
            aluPkg::OP_ROTRV: aluResult = rotPair[dataWidth-1:0];

            // Compares give 0 or 1
            aluPkg::OP_SLT:  aluResult = {{(dataWidth-1){1'b0}}, ltSigned};
            aluPkg::OP_SLTU: aluResult = {{(dataWidth-1){1'b0}}, ltUnsigned};

            aluPkg::OP_MUL: aluResult = mulLow;

            // Moves pass A, write enable decided by condTrue
            aluPkg::OP_MOVN,
            aluPkg::OP_MOVZ: aluResult = s1A;

            // Shamt bit 0 picks halfword over byte
            aluPkg::OP_SEH_SEB: begin
                if (s1Shamt[0]) begin
                    aluResult = {{(dataWidth-16){s1B[15]}}, s1B[15:0]};
                end else begin
                    aluResult = {{(dataWidth-8){s1B[7]}}, s1B[7:0]};
                end
            end

            // HI/LO class and illegal codes
            default: aluResult = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Conditional move test
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (s1Op)
            aluPkg::OP_MOVN: condTrue = (s1B != '0);
            aluPkg::OP_MOVZ: condTrue = (s1B == '0);
            // Not a move, so no condition
            default:         condTrue = 1'b0;
        endcase
    end

endmodule

//--- hiLoUnit.sv
`timescale 1ns/1ps

module hiLoUnit #(
    parameter int dataWidth = aluPkg::DATA_WIDTH_DEF
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 s1Valid,
    input  aluPkg::aluOpT        s1Op,
    input  aluPkg::opClassT      s1Class,
    input  logic [dataWidth-1:0] s1A,
    input  logic [dataWidth-1:0] s1B,
    output logic [dataWidth-1:0] hi,
    output logic [dataWidth-1:0] lo
);

    localparam int accWidth = 2 * dataWidth;

    // HI in the upper half, LO in the lower half
    logic [accWidth-1:0] acc;
    logic [accWidth-1:0] accNext;

    // Full products of the stage 1 operands
    logic [accWidth-1:0] prodSigned;
    logic [accWidth-1:0] prodUnsigned;

    // Update enable
    logic accLoad;

    ////////////////////////////////////////////////////////////
    // Products
    ////////////////////////////////////////////////////////////

    // Sign extended to full width so the low half of the wide product is exact
    assign prodSigned = {{dataWidth{s1A[dataWidth-1]}}, s1A}
                      * {{dataWidth{s1B[dataWidth-1]}}, s1B};

    assign prodUnsigned = {{dataWidth{1'b0}}, s1A} * {{dataWidth{1'b0}}, s1B};

    always_comb begin
        case (s1Op)
            aluPkg::OP_MULT:  accNext = prodSigned;
            aluPkg::OP_MULTU: accNext = prodUnsigned;
            // Carry runs across all 64 bits
            aluPkg::OP_MADD:  accNext = acc + prodSigned;
            aluPkg::OP_MSUB:  accNext = acc - prodSigned;
            default:          accNext = acc;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////

    assign accLoad = s1Valid && (s1Class == aluPkg::CLASS_HILO);

    // Written on the same edge the result stage captures
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (accLoad) begin
            acc <= accNext;
        end
    end

    assign hi = acc[accWidth-1:dataWidth];
    assign lo = acc[dataWidth-1:0];

    // HI/LO hold unless a multiply opcode sat in stage 1
    assert property (@(posedge clk) disable iff (!rstN)
        !(s1Valid && (s1Op == aluPkg::OP_MULT || s1Op == aluPkg::OP_MULTU
                      || s1Op == aluPkg::OP_MADD || s1Op == aluPkg::OP_MSUB))
        |=> $stable({hi, lo}))
        else $error("hiLoUnit: accumulator changed without multiply op");

endmodule

//--- resultStage.sv
`timescale 1ns/1ps

module resultStage #(
    parameter int dataWidth = aluPkg::DATA_WIDTH_DEF
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 s1Valid,
    input  aluPkg::opClassT      s1Class,
    input  logic [dataWidth-1:0] aluResult,
    input  logic                 condTrue,
    output logic [dataWidth-1:0] result,
    output logic                 zero,
    output logic                 regWrite,
    output logic                 resultValid
);

    // Write enable as seen in stage 1
    logic writeNext;

    // Result class always writes and moves only when their test holds
    assign writeNext = (s1Class == aluPkg::CLASS_RESULT)
                    || ((s1Class == aluPkg::CLASS_COND) && condTrue);

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            regWrite    <= 1'b0;
            result      <= '0;
        end else begin
            resultValid <= s1Valid;
            regWrite    <= s1Valid && writeNext;
            // Hold the last result between operations
            if (s1Valid) begin
                result <= aluResult;
            end
        end
    end

    // Flag from the registered value
    assign zero = (result == '0);

    // Multiply-class and illegal ops leave a zero result
    assert property (@(posedge clk) disable iff (!rstN)
        s1Valid && (s1Class == aluPkg::CLASS_HILO || s1Class == aluPkg::CLASS_ILLEGAL)
        |=> (result == '0))
        else $error("resultStage: nonzero result for multiply-class or illegal op");

endmodule

//--- execUnit.sv
`timescale 1ns/1ps

module execUnit #(
    parameter  int dataWidth  = aluPkg::DATA_WIDTH_DEF,
    localparam int shamtWidth = $clog2(dataWidth)
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  issueStb,
    input  aluPkg::aluOpT         op,
    input  logic [dataWidth-1:0]  a,
    input  logic [dataWidth-1:0]  b,
    input  logic [shamtWidth-1:0] shamt,
    output logic [dataWidth-1:0]  result,
    output logic                  zero,
    output logic                  regWrite,
    output logic                  resultValid,
    output logic [dataWidth-1:0]  hi,
    output logic [dataWidth-1:0]  lo
);

    ////////////////////////////////////////////////////////////
    // Stage 1 bundle
    ////////////////////////////////////////////////////////////

    logic                  s1Valid;
    aluPkg::aluOpT         s1Op;
    logic [dataWidth-1:0]  s1A;
    logic [dataWidth-1:0]  s1B;
    logic [shamtWidth-1:0] s1Shamt;
    aluPkg::opClassT       s1Class;

    // Combinational ALU outputs
    logic [dataWidth-1:0] aluResult;
    logic                 condTrue;

    // Issue into stage 1
    operandStage #(.dataWidth(dataWidth)) u_operandStage (
        .clk(clk), .rstN(rstN), .issueStb(issueStb),
        .op(op), .a(a), .b(b), .shamt(shamt),
        .s1Valid(s1Valid), .s1Op(s1Op), .s1A(s1A), .s1B(s1B),
        .s1Shamt(s1Shamt), .s1Class(s1Class)
    );

    aluCore #(.dataWidth(dataWidth)) u_aluCore (
        .s1Op(s1Op), .s1A(s1A), .s1B(s1B), .s1Shamt(s1Shamt),
        .aluResult(aluResult), .condTrue(condTrue)
    );

    // Runs beside the result stage
    hiLoUnit #(.dataWidth(dataWidth)) u_hiLoUnit (
        .clk(clk), .rstN(rstN), .s1Valid(s1Valid), .s1Op(s1Op),
        .s1Class(s1Class), .s1A(s1A), .s1B(s1B),
        .hi(hi), .lo(lo)
    );

    resultStage #(.dataWidth(dataWidth)) u_resultStage (
        .clk(clk), .rstN(rstN), .s1Valid(s1Valid), .s1Class(s1Class),
        .aluResult(aluResult), .condTrue(condTrue),
        .result(result), .zero(zero), .regWrite(regWrite),
        .resultValid(resultValid)
    );

endmodule

//--- tbExecUnit.sv
`timescale 1ns/1ps

module tbExecUnit;

    localparam int dataWidth  = aluPkg::DATA_WIDTH_DEF;
    localparam int shamtWidth = $clog2(dataWidth);
    localparam int clkPeriod  = 8;

    // Operations issued by each test to size the watchdog
    localparam int arithOps  = 10 * (25 + 8);
    localparam int shiftOps  = 6 * 32 + 16;
    localparam int condOps   = 16;
    localparam int hiLoOps   = 24;
    localparam int randOps   = 300;
    localparam int totalOps  = arithOps + shiftOps + condOps + hiLoOps + randOps;
    localparam int timeoutNs = (totalOps + 20) * clkPeriod * 2;

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  issueStb;
    aluPkg::aluOpT         op;
    logic [dataWidth-1:0]  a;
    logic [dataWidth-1:0]  b;
    logic [shamtWidth-1:0] shamt;
    logic [dataWidth-1:0]  result;
    logic                  zero;
    logic                  regWrite;
    logic                  resultValid;
    logic [dataWidth-1:0]  hi;
    logic [dataWidth-1:0]  lo;

    // One outstanding operation and the cycle its result is due
    typedef struct {
        aluPkg::aluOpT        op;
        logic [dataWidth-1:0] result;
        logic                 write;
        logic [dataWidth-1:0] hi;
        logic [dataWidth-1:0] lo;
        int unsigned          due;
    } expT;

    expT                  expQ[$];
    logic [dataWidth-1:0] modelHi = '0;
    logic [dataWidth-1:0] modelLo = '0;
    int unsigned          cycleNum = 0;
    int                   errCount = 0;
    int                   checkedCount = 0;

    execUnit #(.dataWidth(dataWidth)) i_dut (
        .clk(clk), .rstN(rstN), .issueStb(issueStb),
        .op(op), .a(a), .b(b), .shamt(shamt),
        .result(result), .zero(zero), .regWrite(regWrite),
        .resultValid(resultValid), .hi(hi), .lo(lo)
    );

    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic void refAlu(
        input  aluPkg::aluOpT         o,
        input  logic [dataWidth-1:0]  x,
        input  logic [dataWidth-1:0]  y,
        input  logic [shamtWidth-1:0] sh,
        input  logic [dataWidth-1:0]  hiIn,
        input  logic [dataWidth-1:0]  loIn,
        output logic [dataWidth-1:0]  res,
        output logic                  wr,
        output logic [dataWidth-1:0]  hiOut,
        output logic [dataWidth-1:0]  loOut
    );
        longint          prod;
        longint unsigned acc;
        int              rot;
        acc  = {hiIn, loIn};
        prod = longint'($signed(x)) * longint'($signed(y));
        rot  = int'(x[shamtWidth-1:0]);
        res  = '0;
        wr   = 1'b1;
        case (o)
            aluPkg::OP_ADD, aluPkg::OP_ADDU: res = x + y;
            aluPkg::OP_SUB:     res = x - y;
            aluPkg::OP_AND:     res = x & y;
            aluPkg::OP_OR:      res = x | y;
            aluPkg::OP_NOR:     res = ~(x | y);
            aluPkg::OP_XOR:     res = x ^ y;
            aluPkg::OP_SLL:     res = y << sh;
            aluPkg::OP_SRL:     res = y >> sh;
            aluPkg::OP_SRA:     res = $signed(y) >>> sh;
            aluPkg::OP_SLLV:    res = y << rot;
            aluPkg::OP_SRAV:    res = $signed(y) >>> rot;
            // Rotate right where the left part is empty when rot is 0
            aluPkg::OP_ROTRV:   res = (y >> rot) | (y << (dataWidth - rot));
            aluPkg::OP_SLT:     res[0] = $signed(x) < $signed(y);
            aluPkg::OP_SLTU:    res[0] = x < y;
            aluPkg::OP_MUL:     res = prod[dataWidth-1:0];
            aluPkg::OP_SEH_SEB: res = sh[0] ? int'(shortint'(y[15:0])) : int'(byte'(y[7:0]));
            aluPkg::OP_MOVN: begin
                res = x;
                wr  = (y != '0);
            end
            aluPkg::OP_MOVZ: begin
                res = x;
                wr  = (y == '0);
            end
            // Accumulator ops give no register result
            aluPkg::OP_MULT: begin
                acc = 64'(prod);
                wr  = 1'b0;
            end
            aluPkg::OP_MULTU: begin
                acc = 64'(x) * 64'(y);
                wr  = 1'b0;
            end
            aluPkg::OP_MADD: begin
                acc = acc + 64'(prod);
                wr  = 1'b0;
            end
            aluPkg::OP_MSUB: begin
                acc = acc - 64'(prod);
                wr  = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        hiOut = acc[2*dataWidth-1:dataWidth];
        loOut = acc[dataWidth-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////

    task automatic checkResult(input expT e);
        assert (result == e.result) else begin
            $display("mismatch result (%s): got %h expected %h", e.op.name(), result, e.result);
            errCount++;
        end
        assert (zero == (e.result == '0)) else begin
            $display("mismatch zero (%s): got %h expected %h",
                     e.op.name(), zero, (e.result == '0));
            errCount++;
        end
        assert (regWrite == e.write) else begin
            $display("mismatch regWrite (%s): got %h expected %h", e.op.name(), regWrite, e.write);
            errCount++;
        end
        assert (hi == e.hi && lo == e.lo) else begin
            $display("mismatch hi/lo (%s): got %h_%h expected %h_%h",
                     e.op.name(), hi, lo, e.hi, e.lo);
            errCount++;
        end
        checkedCount++;
    endtask

    // All reads see values from before the edge
    always @(posedge clk) begin
        expT e;
        if (resultValid) begin
            assert (expQ.size() != 0) else begin
                $display("resultValid at cycle %0d with no operation outstanding", cycleNum);
                errCount++;
            end
            if (expQ.size() != 0) begin
                e = expQ.pop_front();
                assert (e.due == cycleNum) else begin
                    $display("%s result came at cycle %0d, due at cycle %0d",
                             e.op.name(), cycleNum, e.due);
                    errCount++;
                end
                checkResult(e);
            end
        end else if (expQ.size() != 0) begin
            assert (expQ[0].due > cycleNum) else begin
                $display("%s result did not come two cycles after issue", expQ[0].op.name());
                errCount++;
                expQ.delete(0);
            end
        end
        // DUT samples the issue on this edge and shows the result two edges later
        if (issueStb) begin
            refAlu(op, a, b, shamt, modelHi, modelLo, e.result, e.write, e.hi, e.lo);
            e.op    = op;
            e.due   = cycleNum + 2;
            modelHi = e.hi;
            modelLo = e.lo;
            expQ.push_back(e);
        end
        cycleNum++;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic issueOp(input aluPkg::aluOpT o, input logic [dataWidth-1:0] x,
                           input logic [dataWidth-1:0] y, input logic [shamtWidth-1:0] sh);
        @(posedge clk);
        issueStb <= 1'b1;
        op       <= o;
        a        <= x;
        b        <= y;
        shamt    <= sh;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            issueStb <= 1'b0;
        end
    endtask

    // Wait until every outstanding result is checked
    task automatic drainResults();
        idle(1);
        @(negedge clk);
        while (expQ.size() != 0) @(negedge clk);
    endtask

    task automatic reportTest(input string name, input int startErr);
        $display("test %-8s finished with %0d errors", name, errCount - startErr);
    endtask

    task automatic checkResetState();
        repeat (4) begin
            @(negedge clk);
            assert (!resultValid && !regWrite) else begin
                $display("resultValid or regWrite high before the first issue");
                errCount++;
            end
            assert (hi == '0 && lo == '0 && result == '0) else begin
                $display("mismatch hi/lo/result after reset: got %h %h %h expected 0",
                         hi, lo, result);
                errCount++;
            end
        end
    endtask

    task automatic runArith();
        aluPkg::aluOpT        ops[10];
        logic [dataWidth-1:0] corners[5];
        ops = '{aluPkg::OP_ADD, aluPkg::OP_ADDU, aluPkg::OP_SUB, aluPkg::OP_AND,
                aluPkg::OP_OR, aluPkg::OP_NOR, aluPkg::OP_XOR, aluPkg::OP_SLT,
                aluPkg::OP_SLTU, aluPkg::OP_MUL};
        // Zero, all ones, both sides of the sign boundary, one
        corners = '{32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001};
        foreach (ops[i]) begin
            foreach (corners[j]) begin
                foreach (corners[k]) begin
                    issueOp(ops[i], corners[j], corners[k], '0);
                end
            end
            repeat (8) issueOp(ops[i], $urandom(), $urandom(), '0);
        end
        drainResults();
    endtask

    task automatic runShifts();
        logic [dataWidth-1:0] x;
        logic [dataWidth-1:0] y;
        for (int s = 0; s < dataWidth; s++) begin
            y = $urandom();
            y[dataWidth-1] = s[0];
            issueOp(aluPkg::OP_SLL, $urandom(), y, shamtWidth'(s));
            issueOp(aluPkg::OP_SRL, $urandom(), y, shamtWidth'(s));
            issueOp(aluPkg::OP_SRA, $urandom(), y, shamtWidth'(s));
            // Upper bits of A are noise and only the low bits set the amount
            x = $urandom();
            x[shamtWidth-1:0] = shamtWidth'(s);
            issueOp(aluPkg::OP_SLLV, x, y, '0);
            issueOp(aluPkg::OP_SRAV, x, y, '0);
            issueOp(aluPkg::OP_ROTRV, x, y, '0);
        end
        for (int i = 0; i < 8; i++) begin
            y = $urandom();
            y[7]  = i[0];
            y[15] = i[1];
            issueOp(aluPkg::OP_SEH_SEB, $urandom(), y, shamtWidth'(0));
            issueOp(aluPkg::OP_SEH_SEB, $urandom(), y, shamtWidth'(1));
        end
        drainResults();
    endtask

    task automatic runCondMoves();
        logic [dataWidth-1:0] x;
        for (int i = 0; i < 4; i++) begin
            x = (i == 0) ? '0 : $urandom();
            issueOp(aluPkg::OP_MOVN, x, '0, '0);
            issueOp(aluPkg::OP_MOVN, x, $urandom() | 32'h1, '0);
            issueOp(aluPkg::OP_MOVZ, x, '0, '0);
            issueOp(aluPkg::OP_MOVZ, x, $urandom() | 32'h1, '0);
        end
        drainResults();
    endtask

    task automatic runHiLo();
        aluPkg::aluOpT ops[8];
        ops = '{aluPkg::OP_MULT, aluPkg::OP_MADD, aluPkg::OP_MADD, aluPkg::OP_MSUB,
                aluPkg::OP_MULTU, aluPkg::OP_MSUB, aluPkg::OP_MADD, aluPkg::OP_MULT};
        for (int i = 0; i < hiLoOps; i++) begin
            if (i % 5 == 0) begin
                issueOp(ops[i % 8], 32'h8000_0000, 32'hffff_ffff, '0);
            end else begin
                issueOp(ops[i % 8], $urandom(), $urandom(), '0);
            end
        end
        drainResults();
    endtask

    // About seven issues in ten cycles with random gaps
    task automatic runRandomStream();
        int issued;
        issued = 0;
        while (issued < randOps) begin
            if ($urandom_range(9, 0) < 7) begin
                issueOp(aluPkg::aluOpT'(5'($urandom_range(22, 0))), $urandom(), $urandom(),
                        shamtWidth'($urandom()));
                issued++;
            end else begin
                idle(1);
            end
        end
        drainResults();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int startErr;
        void'($urandom(32'he00a_eafe));
        rstN     = 1'b0;
        issueStb = 1'b0;
        op       = aluPkg::OP_ADD;
        a        = '0;
        b        = '0;
        shamt    = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        startErr = errCount;
        checkResetState();
        reportTest("reset", startErr);
        startErr = errCount;
        runArith();
        reportTest("arith", startErr);
        startErr = errCount;
        runShifts();
        reportTest("shift", startErr);
        startErr = errCount;
        runCondMoves();
        reportTest("condmove", startErr);
        startErr = errCount;
        runHiLo();
        reportTest("hilo", startErr);
        startErr = errCount;
        runRandomStream();
        reportTest("random", startErr);

        $display("total %0d results checked, %0d errors", checkedCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("watchdog expired after %0d ns, %0d results outstanding", timeoutNs, expQ.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb.f
aluPkg.sv
operandStage.sv
aluCore.sv
hiLoUnit.sv
resultStage.sv
execUnit.sv
tbExecUnit.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tbExecUnit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the outcome; a run that stops early has no pass line
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
